//--- compile.f
+incdir+verilog
verilog/mul_unit_pkg.sv
verilog/mul_decode.sv
verilog/mul_byte_array.sv
verilog/mul_result.sv
verilog/mul_unit.sv
verification/mul_unit_sva.sv
verification/mul_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the multiply unit testbench with Verilator.
# The exit status is nonzero if the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module mul_unit_tb -o mul_unit_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/mul_unit_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

//--- verification/mul_unit_sva.sv
//////////////////////////////////////////////////
// concurrent checks on valid timing and rob entry
// passthrough, bound into the multiply unit
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mul_unit_config.svh"

module mul_unit_sva (
  input logic                        clk,
  input logic                        rst,
  input logic                        uop_valid,
  input logic [`ROB_DEPTH_WIDTH-1:0] rob_entry,
  input logic                        result_valid,
  input logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry
);

  a_reset_clears_valid: assert property (@(posedge clk) rst |=> !result_valid)
    else $error("result_valid high on the cycle after reset");

  // one cycle of latency with no bubbles
  a_valid_latency: assert property (@(posedge clk) disable iff (rst)
      result_valid == $past(uop_valid))
    else $error("result_valid does not follow uop_valid by one cycle");

  a_rob_passthrough: assert property (@(posedge clk) disable iff (rst)
      result_valid |-> result_rob_entry == $past(rob_entry))
    else $error("result_rob_entry differs from the issued rob entry");

endmodule

bind mul_unit mul_unit_sva i_sva (
  .clk(clk), .rst(rst), .uop_valid(uop_valid), .rob_entry(rob_entry),
  .result_valid(result_valid), .result_rob_entry(result_rob_entry)
);

`default_nettype wire

//--- verification/mul_unit_tb.sv
//////////////////////////////////////////////////
// directed testbench for the vector multiply unit
// every result is checked one cycle after issue
// against a per-element reference multiply
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mul_unit_config.svh"

module mul_unit_tb;

  localparam int TIMEOUT_CYCLES = 600;  // well above the test length

  logic                        clk;
  logic                        rst;
  logic                        uop_valid;
  logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
  mul_unit_pkg::funct6_e       funct6;
  mul_unit_pkg::funct3_e       funct3;
  mul_unit_pkg::eew_e          vs2_eew;
  logic [`VLEN-1:0]            vs1_data;
  logic                        vs1_valid;
  logic [`VLEN-1:0]            vs2_data;
  logic                        vs2_valid;
  logic [`XLEN-1:0]            rs1_data;
  logic                        rs1_valid;
  logic                        result_valid;
  logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry;
  logic [`VLEN-1:0]            result_data;

  integer                      seed = 25413;
  int                          cycle_count = 0;
  logic [`ROB_DEPTH_WIDTH-1:0] rob_next = '0;
  logic [`VLEN-1:0]            exp_data_q[$];  // expected results in issue order
  logic [`ROB_DEPTH_WIDTH-1:0] exp_rob_q[$];

  mul_unit i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic [`VLEN-1:0] rand_vec();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  //////////////////////////////////////////////////
  // reference model, one element at a time
  //////////////////////////////////////////////////
  function automatic logic [`VLEN-1:0] model_result(
      input logic [5:0] f6, input logic [2:0] f3, input logic [2:0] eew,
      input logic [`VLEN-1:0] v2, input logic [`VLEN-1:0] v1, input logic [`XLEN-1:0] r1);
    int               w;
    logic             s2;
    logic             s1;
    logic             hi;
    logic [63:0]      mask;
    logic [63:0]      ea;
    logic [63:0]      eb;
    logic [63:0]      p;
    logic [`VLEN-1:0] a;
    logic [`VLEN-1:0] b;
    logic [`VLEN-1:0] elem;
    logic [`VLEN-1:0] r;
    w  = (eew == 3'd1) ? 16 : (eew == 3'd2) ? 32 : 8;  // unknown width runs as 8
    s2 = (f6 != mul_unit_pkg::VMULHU);
    s1 = (f6 != mul_unit_pkg::VMULHU) && (f6 != mul_unit_pkg::VMULHSU);
    hi = (f6 == mul_unit_pkg::VMULH) || !s1;
    a  = v2;
    b  = v1;
    if (f3 == mul_unit_pkg::OPMVX) begin
      for (int k = 0; k < `VLEN; k++) begin
        b[k] = r1[k % w];  // scalar broadcast
      end
    end else if (f3 != mul_unit_pkg::OPMVV) begin
      a = '0;
      b = '0;
    end
    mask = (64'd1 << w) - 64'd1;
    r    = '0;
    for (int i = 0; i < `VLEN / w; i++) begin
      ea = 64'(a >> (i * w)) & mask;
      eb = 64'(b >> (i * w)) & mask;
      if (s2 && ea[w-1]) ea = ea | ~mask;
      if (s1 && eb[w-1]) eb = eb | ~mask;
      p = ea * eb;  // exact in the low 2*w bits
      if (hi) p = p >> w;
      elem       = '0;
      elem[63:0] = p & mask;
      r          = r | (elem << (i * w));
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [`VLEN-1:0] got,
                                 input logic [`VLEN-1:0] exp);
    $display("CHECK FAILED: %s = 0x%h, expected 0x%h", name, got, exp);
    $display("tests failed");
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;  // inputs change after the edge
  endtask

  // issue one micro-op, then check its result one cycle later
  task automatic do_op(input mul_unit_pkg::funct6_e f6, input mul_unit_pkg::funct3_e f3,
                       input mul_unit_pkg::eew_e w, input logic [`VLEN-1:0] v2,
                       input logic v2ok, input logic [`VLEN-1:0] v1, input logic v1ok,
                       input logic [`XLEN-1:0] r1, input logic r1ok);
    logic [`VLEN-1:0]            exp_d;
    logic [`ROB_DEPTH_WIDTH-1:0] exp_r;
    funct6    = f6;
    funct3    = f3;
    vs2_eew   = w;
    vs2_data  = v2;
    vs2_valid = v2ok;
    vs1_data  = v1;
    vs1_valid = v1ok;
    rs1_data  = r1;
    rs1_valid = r1ok;
    rob_entry = rob_next;
    uop_valid = 1'b1;
    exp_data_q.push_back(model_result(f6, f3, w, v2ok ? v2 : '0, v1ok ? v1 : '0,
                                      r1ok ? r1 : '0));
    exp_rob_q.push_back(rob_next);
    rob_next = rob_next + 1'b1;
    next_cycle();
    exp_d = exp_data_q.pop_front();
    exp_r = exp_rob_q.pop_front();
    assert (result_valid === 1'b1) else report_mismatch("result_valid", result_valid, 1);
    assert (result_data === exp_d) else report_mismatch("result_data", result_data, exp_d);
    assert (result_rob_entry === exp_r)
      else report_mismatch("result_rob_entry", result_rob_entry, exp_r);
  endtask

  task automatic go_idle();
    uop_valid = 1'b0;
    next_cycle();
    assert (result_valid === 1'b0) else report_mismatch("result_valid", result_valid, '0);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic test_reset_idle();
    repeat (5) begin
      next_cycle();
      assert (result_valid === 1'b0) else report_mismatch("result_valid", result_valid, '0);
    end
  endtask

  task automatic test_vmul_vv();
    for (int e = 0; e < 3; e++) begin
      repeat (3) do_op(mul_unit_pkg::VMUL, mul_unit_pkg::OPMVV, mul_unit_pkg::eew_e'(e),
                       rand_vec(), 1'b1, rand_vec(), 1'b1, $random(seed), 1'b1);
    end
    go_idle();
  endtask

  task automatic test_high_halves();
    mul_unit_pkg::funct6_e hops[3] = '{mul_unit_pkg::VMULH, mul_unit_pkg::VMULHU,
                                       mul_unit_pkg::VMULHSU};
    logic [`VLEN-1:0]      pats[4] = '{{16{8'h80}}, {16{8'hFF}}, {8{16'h8000}},
                                       {4{32'h8000_0000}}};
    for (int o = 0; o < 3; o++) begin
      for (int e = 0; e < 3; e++) begin
        do_op(hops[o], mul_unit_pkg::OPMVV, mul_unit_pkg::eew_e'(e), rand_vec(), 1'b1,
              rand_vec(), 1'b1, '0, 1'b1);
        for (int i = 0; i < 4; i++) begin
          do_op(hops[o], mul_unit_pkg::OPMVV, mul_unit_pkg::eew_e'(e), pats[i], 1'b1,
                pats[i], 1'b1, '0, 1'b1);
          do_op(hops[o], mul_unit_pkg::OPMVV, mul_unit_pkg::eew_e'(e), pats[i], 1'b1,
                pats[(i+1)%4], 1'b1, '0, 1'b1);  // mixed extremes
        end
      end
    end
    go_idle();
  endtask

  task automatic test_scalar_and_invalid();
    for (int e = 0; e < 3; e++) begin
      do_op(mul_unit_pkg::VMUL, mul_unit_pkg::OPMVX, mul_unit_pkg::eew_e'(e),
            rand_vec(), 1'b1, rand_vec(), 1'b1, $random(seed), 1'b1);
      do_op(mul_unit_pkg::VMULH, mul_unit_pkg::OPMVX, mul_unit_pkg::eew_e'(e),
            rand_vec(), 1'b1, rand_vec(), 1'b0, 32'h8000_0080, 1'b1);
      do_op(mul_unit_pkg::VMULHSU, mul_unit_pkg::OPMVX, mul_unit_pkg::eew_e'(e),
            rand_vec(), 1'b1, rand_vec(), 1'b1, $random(seed), 1'b0);  // rs1 reads zero
      do_op(mul_unit_pkg::VMUL, mul_unit_pkg::OPMVV, mul_unit_pkg::eew_e'(e),
            rand_vec(), 1'b0, rand_vec(), 1'b1, $random(seed), 1'b1);
      do_op(mul_unit_pkg::VMULHU, mul_unit_pkg::OPMVV, mul_unit_pkg::eew_e'(e),
            rand_vec(), 1'b1, rand_vec(), 1'b0, $random(seed), 1'b1);
    end
    go_idle();
  endtask

  task automatic test_back_to_back();
    mul_unit_pkg::funct6_e ops[4] = '{mul_unit_pkg::VMUL, mul_unit_pkg::VMULH,
                                      mul_unit_pkg::VMULHU, mul_unit_pkg::VMULHSU};
    for (int i = 0; i < 10; i++) begin
      do_op(ops[i%4], (i % 2 == 1) ? mul_unit_pkg::OPMVX : mul_unit_pkg::OPMVV,
            mul_unit_pkg::eew_e'(i % 3), rand_vec(), 1'b1, rand_vec(), 1'b1,
            $random(seed), 1'b1);
    end
    go_idle();
  endtask

  task automatic test_bad_funct3();
    logic [2:0] codes[3] = '{3'd0, 3'd1, 3'd7};
    for (int i = 0; i < 3; i++) begin
      do_op(mul_unit_pkg::VMUL, mul_unit_pkg::funct3_e'(codes[i]), mul_unit_pkg::EEW32,
            rand_vec(), 1'b1, rand_vec(), 1'b1, $random(seed), 1'b1);
    end
    go_idle();
  endtask

  initial begin
    rst       = 1'b1;
    uop_valid = 1'b1;  // issued while rst is high, must be dropped
    rob_entry = '0;
    funct6    = mul_unit_pkg::VMUL;
    funct3    = mul_unit_pkg::OPMVV;
    vs2_eew   = mul_unit_pkg::EEW8;
    vs1_data  = '0;
    vs1_valid = 1'b0;
    vs2_data  = '0;
    vs2_valid = 1'b0;
    rs1_data  = '0;
    rs1_valid = 1'b0;
    repeat (3) @(posedge clk);
    #10;
    assert (result_valid === 1'b0) else report_mismatch("result_valid", result_valid, '0);
    uop_valid = 1'b0;
    @(posedge clk);
    #10;
    rst = 1'b0;
    test_reset_idle();
    test_vmul_vv();
    test_high_halves();
    test_scalar_and_invalid();
    test_back_to_back();
    test_bad_funct3();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/mul_byte_array.sv
//////////////////////////////////////////////////
// execute stage with 64 signed/unsigned 8x8 tiles
// products and control are registered here,
// giving the unit its single cycle of latency
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mul_unit_config.svh"

module mul_byte_array (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               op_valid,
  input  logic [`VLEN-1:0]                   src2_bytes,
  input  logic [`VLEN-1:0]                   src1_bytes,
  input  logic [`VLEN_BYTES-1:0]             src2_signed_mask,
  input  logic [`VLEN_BYTES-1:0]             src1_signed_mask,
  input  logic                               keep_low,
  input  mul_unit_pkg::eew_e                 eew,
  input  logic [`ROB_DEPTH_WIDTH-1:0]        op_rob_entry,
  output logic                               prod_valid,
  output logic [`MUL_TILES-1:0][15:0]        products,
  output logic [`MUL_TILES-1:0]              prod_signed,
  output mul_unit_pkg::eew_e                 prod_eew,
  output logic                               prod_keep_low,
  output logic [`ROB_DEPTH_WIDTH-1:0]        prod_rob_entry
);

  logic [`MUL_TILES-1:0][15:0] tile_prod;
  logic [`MUL_TILES-1:0]       tile_signed;

  //////////////////////////////////////////////////
  // tile array, 4x4 per 32-bit group
  //////////////////////////////////////////////////
  for (genvar g = 0; g < `MUL_LANES; g++) begin : g_lane
    for (genvar y = 0; y < 4; y++) begin : g_row
      for (genvar x = 0; x < 4; x++) begin : g_col
        localparam int T = g*16 + y*4 + x;  // tile index
        localparam int A = g*4 + x;         // src2 byte
        localparam int B = g*4 + y;         // src1 byte

        logic signed [8:0]  a_ext;
        logic signed [8:0]  b_ext;
        logic signed [17:0] p_full;

        assign a_ext  = {src2_signed_mask[A] & src2_bytes[8*A+7], src2_bytes[8*A +: 8]};
        assign b_ext  = {src1_signed_mask[B] & src1_bytes[8*B+7], src1_bytes[8*B +: 8]};
        assign p_full = a_ext * b_ext;

        assign tile_prod[T]   = p_full[15:0];  // 16 bits always hold the product
        assign tile_signed[T] = src2_signed_mask[A] | src1_signed_mask[B];
      end
    end
  end

  //////////////////////////////////////////////////
  // pipeline register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    products       <= tile_prod;
    prod_signed    <= tile_signed;  // sign-extend flag per product
    prod_eew       <= eew;
    prod_keep_low  <= keep_low;
    prod_rob_entry <= op_rob_entry;
  end

endmodule

`default_nettype wire

//--- verilog/mul_decode.sv
//////////////////////////////////////////////////
// decode stage of the vector multiply unit
// picks operands, byte sign masks and the half
// to keep; purely combinational
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mul_unit_config.svh"

module mul_decode (
  input  logic                        uop_valid,
  input  mul_unit_pkg::funct6_e       funct6,
  input  mul_unit_pkg::funct3_e       funct3,
  input  mul_unit_pkg::eew_e          vs2_eew,
  input  logic [`VLEN-1:0]            vs1_data,
  input  logic [`VLEN-1:0]            vs2_data,
  input  logic                        vs1_valid,
  input  logic                        vs2_valid,
  input  logic                        rs1_valid,
  input  logic [`XLEN-1:0]            rs1_data,
  input  logic [`ROB_DEPTH_WIDTH-1:0] rob_entry,
  output logic                        op_valid,
  output logic [`VLEN-1:0]            src2_bytes,
  output logic [`VLEN-1:0]            src1_bytes,
  output logic [`VLEN_BYTES-1:0]      src2_signed_mask,
  output logic [`VLEN_BYTES-1:0]      src1_signed_mask,
  output logic                        keep_low,
  output mul_unit_pkg::eew_e          eew,
  output logic [`ROB_DEPTH_WIDTH-1:0] op_rob_entry
);

  logic             src2_signed;
  logic             src1_signed;
  logic [`VLEN-1:0] vs2_eff;
  logic [`VLEN-1:0] vs1_eff;
  logic [`XLEN-1:0] rs1_eff;
  logic [`VLEN-1:0] rs1_bcast;

  assign vs2_eff = vs2_valid ? vs2_data : '0;  // invalid operand reads zero
  assign vs1_eff = vs1_valid ? vs1_data : '0;
  assign rs1_eff = rs1_valid ? rs1_data : '0;

  //////////////////////////////////////////////////
  // signedness and half select from funct6
  //////////////////////////////////////////////////
  always_comb begin
    src2_signed = 1'b1;  // vmul and unknown codes
    src1_signed = 1'b1;
    keep_low    = 1'b1;
    case (funct6)
      mul_unit_pkg::VMULH: begin
        keep_low = 1'b0;
      end
      mul_unit_pkg::VMULHU: begin
        src2_signed = 1'b0;
        src1_signed = 1'b0;
        keep_low    = 1'b0;
      end
      mul_unit_pkg::VMULHSU: begin
        src1_signed = 1'b0;  // vs1/rs1 unsigned
        keep_low    = 1'b0;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // scalar broadcast and sign bit placement
  //////////////////////////////////////////////////
  always_comb begin
    case (vs2_eew)
      mul_unit_pkg::EEW16: begin
        rs1_bcast        = {(`VLEN/16){rs1_eff[15:0]}};
        src2_signed_mask = {(`VLEN_BYTES/2){src2_signed, 1'b0}};  // top byte of halfword
        src1_signed_mask = {(`VLEN_BYTES/2){src1_signed, 1'b0}};
      end
      mul_unit_pkg::EEW32: begin
        rs1_bcast        = {(`VLEN/32){rs1_eff[31:0]}};
        src2_signed_mask = {(`VLEN_BYTES/4){src2_signed, 3'b0}};  // top byte of word
        src1_signed_mask = {(`VLEN_BYTES/4){src1_signed, 3'b0}};
      end
      default: begin
        rs1_bcast        = {(`VLEN/8){rs1_eff[7:0]}};
        src2_signed_mask = {`VLEN_BYTES{src2_signed}};
        src1_signed_mask = {`VLEN_BYTES{src1_signed}};
      end
    endcase
  end

  // operand routing with zero for an unsupported category
  always_comb begin
    case (funct3)
      mul_unit_pkg::OPMVV: begin
        src2_bytes = vs2_eff;
        src1_bytes = vs1_eff;
      end
      mul_unit_pkg::OPMVX: begin
        src2_bytes = vs2_eff;
        src1_bytes = rs1_bcast;
      end
      default: begin
        src2_bytes = '0;
        src1_bytes = '0;
      end
    endcase
  end

  assign op_valid     = uop_valid;
  assign eew          = vs2_eew;
  assign op_rob_entry = rob_entry;

endmodule

`default_nettype wire

//--- verilog/mul_result.sv
//////////////////////////////////////////////////
// result stage that sums registered tile products
// into 8/16/32-bit elements and keeps the low
// or high half; purely combinational
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mul_unit_config.svh"

module mul_result (
  input  logic                               prod_valid,
  input  logic [`MUL_TILES-1:0][15:0]        products,
  input  logic [`MUL_TILES-1:0]              prod_signed,
  input  mul_unit_pkg::eew_e                 prod_eew,
  input  logic                               prod_keep_low,
  input  logic [`ROB_DEPTH_WIDTH-1:0]        prod_rob_entry,
  output logic                               result_valid,
  output logic [`VLEN-1:0]                   result_data,
  output logic [`ROB_DEPTH_WIDTH-1:0]        result_rob_entry
);

  logic [15:0]      full8  [`VLEN_BYTES];
  logic [31:0]      full16 [`VLEN_BYTES/2];
  logic [63:0]      full32 [`MUL_LANES];
  logic [`VLEN-1:0] res8;
  logic [`VLEN-1:0] res16;
  logic [`VLEN-1:0] res32;

  // widen one tile product to 64 bits
  function automatic logic [63:0] sext_prod(input logic [15:0] p, input logic s);
    return {{48{s & p[15]}}, p};
  endfunction

  //////////////////////////////////////////////////
  // partial product accumulation
  //////////////////////////////////////////////////
  always_comb begin
    int t;
    int base;
    for (int b = 0; b < `VLEN_BYTES; b++) begin
      full8[b] = products[(b/4)*16 + (b%4)*5];  // diagonal tile
    end
    for (int e = 0; e < `VLEN_BYTES/2; e++) begin
      base      = (e%2)*2;  // first byte of halfword in group
      full16[e] = '0;
      for (int y = 0; y < 2; y++) begin
        for (int x = 0; x < 2; x++) begin
          t         = (e/2)*16 + (base+y)*4 + base + x;
          full16[e] = full16[e] + 32'(sext_prod(products[t], prod_signed[t]) << (8*(x+y)));
        end
      end
    end
    for (int g = 0; g < `MUL_LANES; g++) begin
      full32[g] = '0;
      for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
          t         = g*16 + y*4 + x;
          full32[g] = full32[g] + (sext_prod(products[t], prod_signed[t]) << (8*(x+y)));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // half select and packing
  //////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < `VLEN_BYTES; i++) begin
      res8[8*i +: 8] = prod_keep_low ? full8[i][7:0] : full8[i][15:8];
    end
    for (int i = 0; i < `VLEN_BYTES/2; i++) begin
      res16[16*i +: 16] = prod_keep_low ? full16[i][15:0] : full16[i][31:16];
    end
    for (int i = 0; i < `MUL_LANES; i++) begin
      res32[32*i +: 32] = prod_keep_low ? full32[i][31:0] : full32[i][63:32];
    end
  end

  always_comb begin
    case (prod_eew)
      mul_unit_pkg::EEW16: result_data = res16;
      mul_unit_pkg::EEW32: result_data = res32;
      default:             result_data = res8;  // eew8 and unknown widths
    endcase
  end

  assign result_valid     = prod_valid;
  assign result_rob_entry = prod_rob_entry;

endmodule

`default_nettype wire

//--- verilog/mul_unit.sv
//////////////////////////////////////////////////
// vector multiply execution unit, top level
// one micro-op per cycle in, result one cycle
// later; the consumer must always accept
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mul_unit_config.svh"

module mul_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        uop_valid,
  input  logic [`ROB_DEPTH_WIDTH-1:0] rob_entry,
  input  mul_unit_pkg::funct6_e       funct6,
  input  mul_unit_pkg::funct3_e       funct3,
  input  mul_unit_pkg::eew_e          vs2_eew,
  input  logic [`VLEN-1:0]            vs1_data,
  input  logic                        vs1_valid,
  input  logic [`VLEN-1:0]            vs2_data,
  input  logic                        vs2_valid,
  input  logic [`XLEN-1:0]            rs1_data,
  input  logic                        rs1_valid,
  output logic                        result_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry,
  output logic [`VLEN-1:0]            result_data
);

  // decode to execute
  logic                        op_valid;
  logic [`VLEN-1:0]            src2_bytes;
  logic [`VLEN-1:0]            src1_bytes;
  logic [`VLEN_BYTES-1:0]      src2_signed_mask;
  logic [`VLEN_BYTES-1:0]      src1_signed_mask;
  logic                        keep_low;
  mul_unit_pkg::eew_e          eew;
  logic [`ROB_DEPTH_WIDTH-1:0] op_rob_entry;

  // execute to result
  logic                        prod_valid;
  logic [`MUL_TILES-1:0][15:0] products;
  logic [`MUL_TILES-1:0]       prod_signed;
  mul_unit_pkg::eew_e          prod_eew;
  logic                        prod_keep_low;
  logic [`ROB_DEPTH_WIDTH-1:0] prod_rob_entry;

  mul_decode u_decode (
    .uop_valid, .funct6, .funct3, .vs2_eew,
    .vs1_data, .vs2_data, .vs1_valid, .vs2_valid,
    .rs1_valid, .rs1_data, .rob_entry,
    .op_valid, .src2_bytes, .src1_bytes,
    .src2_signed_mask, .src1_signed_mask,
    .keep_low, .eew, .op_rob_entry
  );

  mul_byte_array u_execute (
    .clk, .rst, .op_valid, .src2_bytes, .src1_bytes,
    .src2_signed_mask, .src1_signed_mask,
    .keep_low, .eew, .op_rob_entry,
    .prod_valid, .products, .prod_signed,
    .prod_eew, .prod_keep_low, .prod_rob_entry
  );

  mul_result u_result (
    .prod_valid, .products, .prod_signed,
    .prod_eew, .prod_keep_low, .prod_rob_entry,
    .result_valid, .result_data, .result_rob_entry
  );

endmodule

`default_nettype wire

//--- verilog/mul_unit_config.svh
//////////////////////////////////////////////////
// sizing macros for the vector multiply unit
// include in every file that needs a width
//////////////////////////////////////////////////

`ifndef MUL_UNIT_CONFIG_SVH
`define MUL_UNIT_CONFIG_SVH

`define VLEN            128  // vector register width
`define XLEN            32   // scalar rs1 width
`define ROB_DEPTH_WIDTH 4    // rob entry index

`define VLEN_BYTES      16   // 8-bit operand slices per vector
`define MUL_LANES       4    // 32-bit tile groups
`define MUL_TILES       64   // 4 groups of 4x4 byte products

`endif

//--- verilog/mul_unit_pkg.sv
//////////////////////////////////////////////////
// encodings shared by the multiply unit and its
// testbench, referenced by scoped names only
//////////////////////////////////////////////////

`default_nettype none

package mul_unit_pkg;

  //////////////////////////////////////////////////
  // element width of vs2
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    EEW8  = 3'd0,
    EEW16 = 3'd1,
    EEW32 = 3'd2  // anything else runs as eew8
  } eew_e;

  //////////////////////////////////////////////////
  // operand category
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    OPMVV = 3'd2,  // vector-vector
    OPMVX = 3'd6   // vector-scalar, rs1 broadcast
  } funct3_e;

  //////////////////////////////////////////////////
  // multiply operations
  //////////////////////////////////////////////////
  typedef enum logic [5:0] {
    VMULHU  = 6'h24,  // unsigned x unsigned, high half
    VMUL    = 6'h25,  // low half, also the fallback
    VMULHSU = 6'h26,  // signed vs2 x unsigned vs1
    VMULH   = 6'h27   // signed x signed, high half
  } funct6_e;

endpackage

`default_nettype wire
